//--- hdl/clint_defines.svh
`ifndef CLINT_DEFINES_SVH
`define CLINT_DEFINES_SVH

// Harts served by this build
`define CLINT_NUM_CORES 2

// Core index width, kept at one bit for a single hart
`define CLINT_CORE_W ((`CLINT_NUM_CORES == 1) ? 1 : $clog2(`CLINT_NUM_CORES))

// Register offsets within the 64 KiB CLINT window
`define CLINT_MSIP_BASE     16'h0000 // 4 bytes per hart
`define CLINT_MTIMECMP_BASE 16'h4000 // 8 bytes per hart, low word first
`define CLINT_MTIME_LO      16'hBFF8
`define CLINT_MTIME_HI      16'hBFFC

// Software sees mtime as two 32-bit halves at consecutive words
// msip and mtimecmp repeat with a fixed stride per hart
// Offsets past the last hart are left unmapped

`endif

//--- hdl/clint_bus_pkg.sv
// Software register port of the CLINT
package clint_bus_pkg;

    // Access kind of one request
    typedef enum logic {
        CLINT_OP_READ  = 1'b0,
        CLINT_OP_WRITE = 1'b1
    } clint_op_e;

    // One access, presented for a single cycle
    typedef struct packed {
        logic        valid; // Single-cycle strobe
        clint_op_e   op;
        logic [15:0] addr;  // Byte offset into the CLINT window
        logic [31:0] wdata; // Ignored on reads
    } clint_req_t;

    // Read data returns one cycle after the request
    typedef struct packed {
        logic        valid; // Single-cycle strobe
        logic [31:0] rdata;
    } clint_rsp_t;

    // No ready or error signals, the port never stalls
    // Writes produce no response

endpackage

//--- hdl/clint_reg_pkg.sv
`include "clint_defines.svh"

// Register-side types shared by the decoder, the register blocks and the combiner
package clint_reg_pkg;

    // Register named by a decoded address
    typedef enum logic [2:0] {
        REG_NONE,        // Unmapped offset
        REG_MSIP,
        REG_MTIMECMP_LO,
        REG_MTIMECMP_HI,
        REG_MTIME_LO,
        REG_MTIME_HI
    } clint_reg_e;

    // Decoded write, at most one strobe high
    typedef struct packed {
        logic                     wr_mtime;
        logic                     wr_mtimecmp;
        logic                     wr_msip;
        logic                     upper; // High half, mtime and mtimecmp only
        logic [`CLINT_CORE_W-1:0] core;  // Target hart for msip and mtimecmp
        logic [31:0]              data;
    } clint_wr_t;

    // Decoded read
    typedef struct packed {
        logic                     valid;
        clint_reg_e               sel;
        logic [`CLINT_CORE_W-1:0] core;
    } clint_rd_t;

    // Interrupt lines of one hart
    typedef struct packed {
        logic msip;
        logic mtip;
    } clint_irq_t;

endpackage

//--- hdl/clint_reg_decode.sv
`include "clint_defines.svh"

module clint_reg_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  clint_bus_pkg::clint_req_t req,
    output clint_reg_pkg::clint_wr_t  wr,
    output clint_reg_pkg::clint_rd_t  rd
);

    logic [15:0]              msip_off;    // Offset into msip window
    logic [15:0]              cmp_off;     // Offset into mtimecmp window
    logic                     msip_hit;
    logic                     cmp_hit;
    logic                     is_write;
    clint_reg_pkg::clint_reg_e sel;
    logic [`CLINT_CORE_W-1:0] core;

    assign msip_off = req.addr - `CLINT_MSIP_BASE;
    assign cmp_off  = req.addr - `CLINT_MTIMECMP_BASE;

    // Word aligned and below the hart count, anything else is a hole
    assign msip_hit = (msip_off[1:0] == 2'b00) && (msip_off[15:2] < `CLINT_NUM_CORES);
    assign cmp_hit  = (cmp_off[1:0] == 2'b00) && (cmp_off[15:3] < `CLINT_NUM_CORES);

    always_comb begin
        sel  = clint_reg_pkg::REG_NONE;
        core = '0;
        if (req.addr == `CLINT_MTIME_LO) begin
            sel = clint_reg_pkg::REG_MTIME_LO;
        end else if (req.addr == `CLINT_MTIME_HI) begin
            sel = clint_reg_pkg::REG_MTIME_HI;
        end else if (msip_hit) begin
            sel  = clint_reg_pkg::REG_MSIP;
            core = msip_off[`CLINT_CORE_W+1:2]; // 4-byte stride
        end else if (cmp_hit) begin
            // Bit 2 picks the half, low word first
            sel  = cmp_off[2] ? clint_reg_pkg::REG_MTIMECMP_HI : clint_reg_pkg::REG_MTIMECMP_LO;
            core = cmp_off[`CLINT_CORE_W+2:3]; // 8-byte stride
        end
    end

    assign is_write = req.valid && (req.op == clint_bus_pkg::CLINT_OP_WRITE);

    // Write command, unmapped offsets raise no strobe
    assign wr.wr_mtime    = is_write && ((sel == clint_reg_pkg::REG_MTIME_LO) ||
                                         (sel == clint_reg_pkg::REG_MTIME_HI));
    assign wr.wr_mtimecmp = is_write && ((sel == clint_reg_pkg::REG_MTIMECMP_LO) ||
                                         (sel == clint_reg_pkg::REG_MTIMECMP_HI));
    assign wr.wr_msip     = is_write && (sel == clint_reg_pkg::REG_MSIP);
    assign wr.upper       = (sel == clint_reg_pkg::REG_MTIME_HI) ||
                            (sel == clint_reg_pkg::REG_MTIMECMP_HI);
    assign wr.core        = core;
    assign wr.data        = req.wdata;

    // Read select, REG_NONE reads back as zero downstream
    assign rd.valid = req.valid && (req.op == clint_bus_pkg::CLINT_OP_READ);
    assign rd.sel   = sel;
    assign rd.core  = core;

    // Only one register block may be written per request
    a_one_wr_strobe: assert property (@(posedge clk) disable iff (rst)
        $onehot0({wr.wr_mtime, wr.wr_mtimecmp, wr.wr_msip}));

endmodule

//--- hdl/clint_timer.sv
`include "clint_defines.svh"

module clint_timer (
    input  logic                                   clk,
    input  logic                                   rst,
    input  clint_reg_pkg::clint_wr_t               wr,
    output logic [63:0]                            mtime,
    output logic [`CLINT_NUM_CORES-1:0][63:0]      mtimecmp,
    output logic [`CLINT_NUM_CORES-1:0]            mtip
);

    logic [63:0] mtime_inc; // Next count when nothing is written

    assign mtime_inc = mtime + 64'd1;

    // mtime runs every clk, a half-word write overrides only its half
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime <= '0;
        end else begin
            mtime[63:32] <= (wr.wr_mtime && wr.upper) ? wr.data : mtime_inc[63:32];
            mtime[31:0]  <= (wr.wr_mtime && !wr.upper) ? wr.data : mtime_inc[31:0];
        end
    end

    // Compare registers start at max so no timer fires out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp <= '1;
        end else begin
            for (int i = 0; i < `CLINT_NUM_CORES; i++) begin
                if (wr.wr_mtimecmp && (i == int'(wr.core))) begin
                    if (wr.upper) begin
                        mtimecmp[i][63:32] <= wr.data;
                    end else begin
                        mtimecmp[i][31:0] <= wr.data;
                    end
                end
            end
        end
    end

    // Registered compare on pre-edge values
    // so mtip trails mtime and mtimecmp by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            mtip <= '0;
        end else begin
            for (int i = 0; i < `CLINT_NUM_CORES; i++) begin
                mtip[i] <= (mtime >= mtimecmp[i]); // Unsigned 64-bit compare
            end
        end
    end

    // A full 64-bit update takes two writes
    // Software writes the high half last or parks mtimecmp at max meanwhile
    // mtime keeps counting between the two half writes

    // No timer interrupt may be seen on the first cycle out of reset
    a_mtip_clear_after_rst: assert property (@(posedge clk)
        $fell(rst) |-> (mtip == '0));

endmodule

//--- hdl/clint_swi.sv
`include "clint_defines.svh"

module clint_swi (
    input  logic                        clk,
    input  logic                        rst,
    input  clint_reg_pkg::clint_wr_t    wr,
    output logic [`CLINT_NUM_CORES-1:0] msip
);

    // One software interrupt bit per hart
    // A write loads data bit 0 into the addressed hart, upper bits ignored
    always_ff @(posedge clk) begin
        if (rst) begin
            msip <= '0;
        end else if (wr.wr_msip) begin
            msip[wr.core] <= wr.data[0]; // LSB
        end
    end

    // Other harts keep their bit on a msip write
    // Bits persist until software clears them
    // The bit drives the hart's irq line with no extra stage

    // Decoder must never hand over a hart beyond the last one
    a_msip_core_range: assert property (@(posedge clk) disable iff (rst)
        wr.wr_msip |-> (int'(wr.core) < `CLINT_NUM_CORES));

endmodule

//--- hdl/clint_irq_merge.sv
`include "clint_defines.svh"

module clint_irq_merge (
    input  logic                                           clk,
    input  logic                                           rst,
    input  clint_reg_pkg::clint_rd_t                       rd,
    input  logic [63:0]                                    mtime,
    input  logic [`CLINT_NUM_CORES-1:0][63:0]              mtimecmp,
    input  logic [`CLINT_NUM_CORES-1:0]                    mtip,
    input  logic [`CLINT_NUM_CORES-1:0]                    msip,
    output clint_bus_pkg::clint_rsp_t                      rsp,
    output clint_reg_pkg::clint_irq_t [`CLINT_NUM_CORES-1:0] irq
);

    logic [31:0] rdata_d;   // Word picked this cycle
    logic        rsp_valid_q;
    logic [31:0] rsp_rdata_q;

    // Read mux, unmapped selects read as zero
    always_comb begin
        case (rd.sel)
            clint_reg_pkg::REG_MSIP:        rdata_d = {31'd0, msip[rd.core]}; // Zero-extended
            clint_reg_pkg::REG_MTIMECMP_LO: rdata_d = mtimecmp[rd.core][31:0];
            clint_reg_pkg::REG_MTIMECMP_HI: rdata_d = mtimecmp[rd.core][63:32];
            clint_reg_pkg::REG_MTIME_LO:    rdata_d = mtime[31:0];
            clint_reg_pkg::REG_MTIME_HI:    rdata_d = mtime[63:32];
            default:                        rdata_d = '0;
        endcase
    end

    // Fixed one-cycle read latency
    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= rd.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rd.valid) begin
            rsp_rdata_q <= rdata_d; // Holds value from before the edge
        end
    end

    assign rsp.valid = rsp_valid_q;
    assign rsp.rdata = rsp_rdata_q;

    // Per-hart interrupt lines
    always_comb begin
        for (int i = 0; i < `CLINT_NUM_CORES; i++) begin
            irq[i].msip = msip[i]; // Straight from the register
            irq[i].mtip = mtip[i]; // Already registered in the timer
        end
    end

    // Every read request gets exactly one response on the next cycle
    a_rsp_after_rd: assert property (@(posedge clk) disable iff (rst)
        rd.valid |=> rsp.valid);
    a_no_stray_rsp: assert property (@(posedge clk) disable iff (rst)
        !rd.valid |=> !rsp.valid);

endmodule

//--- hdl/clint_top.sv
`include "clint_defines.svh"

module clint_top (
    input  logic                                            clk,
    input  logic                                            rst,
    input  clint_bus_pkg::clint_req_t                       req,
    output clint_bus_pkg::clint_rsp_t                       rsp,
    output clint_reg_pkg::clint_irq_t [`CLINT_NUM_CORES-1:0] irq
);

    clint_reg_pkg::clint_wr_t              wr;       // Decoded write
    clint_reg_pkg::clint_rd_t              rd;       // Decoded read
    logic [63:0]                           mtime;
    logic [`CLINT_NUM_CORES-1:0][63:0]     mtimecmp;
    logic [`CLINT_NUM_CORES-1:0]           mtip;
    logic [`CLINT_NUM_CORES-1:0]           msip;

    // Address decode, same cycle as the request
    clint_reg_decode clint_reg_decode_i (
        .clk (clk),
        .rst (rst),
        .req (req),
        .wr  (wr),
        .rd  (rd)
    );

    // Timer and software interrupt banks share the write command
    clint_timer clint_timer_i (
        .clk      (clk),
        .rst      (rst),
        .wr       (wr),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .mtip     (mtip)
    );

    clint_swi clint_swi_i (
        .clk  (clk),
        .rst  (rst),
        .wr   (wr),
        .msip (msip)
    );

    // Read response and per-hart irq lines
    clint_irq_merge clint_irq_merge_i (
        .clk      (clk),
        .rst      (rst),
        .rd       (rd),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .mtip     (mtip),
        .msip     (msip),
        .rsp      (rsp),
        .irq      (irq)
    );

endmodule

//--- tests/clint_tb.sv
`include "clint_defines.svh"

module clint_tb;

    localparam int RUN_CYCLES = 3000;
    localparam int CLK_PERIOD = 8;
    localparam int WATCHDOG   = (RUN_CYCLES + 100) * CLK_PERIOD; // Run plus slack for reset

    logic                                             clk;
    logic                                             rst;
    clint_bus_pkg::clint_req_t                        req;
    clint_bus_pkg::clint_rsp_t                        rsp;
    clint_reg_pkg::clint_irq_t [`CLINT_NUM_CORES-1:0] irq;

    // Reference state, always the value after the most recent rising edge
    logic [63:0] m_mtime;
    logic [63:0] m_cmp [`CLINT_NUM_CORES];
    logic        m_msip [`CLINT_NUM_CORES];
    logic        m_mtip [`CLINT_NUM_CORES];

    // Request in flight, kind 0 unmapped, 1 msip, 2/3 cmp lo/hi, 4/5 mtime lo/hi
    int          cur_kind;
    int          cur_core;
    logic        cur_rd;
    logic        cur_wr;
    logic [31:0] cur_wdata;
    logic        exp_valid;  // Response due at the next check
    logic [31:0] exp_rdata;
    int          exp_kind;
    int          errors;
    int          cyc;

    clint_top clint_top_i (.clk(clk), .rst(rst), .req(req), .rsp(rsp), .irq(irq));

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Byte offset for a register kind, straight from the CLINT map
    function automatic logic [15:0] kind_addr(input int kind, input int core, input int pick);
        case (kind)
            1: return `CLINT_MSIP_BASE + 16'(4 * core);
            2: return `CLINT_MTIMECMP_BASE + 16'(8 * core);
            3: return `CLINT_MTIMECMP_BASE + 16'(8 * core + 4);
            4: return `CLINT_MTIME_LO;
            5: return `CLINT_MTIME_HI;
            default: begin
                case (pick) // Holes just past each window, plus misaligned offsets
                    0: return `CLINT_MSIP_BASE + 16'(4 * `CLINT_NUM_CORES);
                    1: return `CLINT_MTIMECMP_BASE + 16'(8 * `CLINT_NUM_CORES);
                    2: return 16'h4002;
                    default: return 16'hBFF0;
                endcase
            end
        endcase
    endfunction

    task automatic check_outputs();
        assert (rsp.valid == exp_valid) else begin
            errors++;
            $display("Mismatch at %0t: rsp.valid %b expected %b", $time, rsp.valid, exp_valid);
        end
        if (exp_valid) begin
            assert (rsp.rdata == exp_rdata) else begin
                errors++;
                $display("Mismatch at %0t: read kind %0d rdata %h expected %h",
                         $time, exp_kind, rsp.rdata, exp_rdata);
            end
        end
        for (int i = 0; i < `CLINT_NUM_CORES; i++) begin
            assert (irq[i].msip == m_msip[i] && irq[i].mtip == m_mtip[i]) else begin
                errors++;
                $display("Mismatch at %0t: core %0d msip/mtip %b%b expected %b%b", $time, i,
                         irq[i].msip, irq[i].mtip, m_msip[i], m_mtip[i]);
            end
        end
    endtask

    task automatic pick_request(input int n);
        int          r;
        logic [63:0] near;
        r         = $urandom % 8;   // 0-1 idle, 2-4 read, 5-7 write
        cur_rd    = (r >= 2) && (r < 5);
        cur_wr    = (r >= 5);
        cur_kind  = ($urandom % 8 == 0) ? 0 : 1 + $urandom % 5;
        cur_core  = $urandom % `CLINT_NUM_CORES;
        cur_wdata = $urandom;
        if (n < 2 * `CLINT_NUM_CORES) begin // Read every mtimecmp half out of reset
            cur_rd   = 1'b1;
            cur_wr   = 1'b0;
            cur_kind = 2 + n % 2;
            cur_core = n / 2;
        end
        near = m_mtime + 64'($urandom % 48) - 64'd16; // Lands just behind or ahead of mtime
        case (cur_kind)
            2: if ($urandom % 4 != 0) cur_wdata = near[31:0];
            3: if ($urandom % 4 != 0) cur_wdata = near[63:32];
            4: if ($urandom % 4 == 0) cur_wdata = 32'hFFFF_FF00 | ($urandom % 256); // Carry
            default: ;
        endcase
        req.valid = cur_rd || cur_wr;
        req.op    = cur_wr ? clint_bus_pkg::CLINT_OP_WRITE : clint_bus_pkg::CLINT_OP_READ;
        req.addr  = kind_addr(cur_kind, cur_core, $urandom % 4);
        req.wdata = cur_wdata;
    endtask

    // Advance the model across the next rising edge
    task automatic step_model();
        logic [63:0] next_mtime;
        exp_valid = cur_rd;
        exp_kind  = cur_kind;
        case (cur_kind) // Read data comes from pre-edge values
            1: exp_rdata = {31'd0, m_msip[cur_core]};
            2: exp_rdata = m_cmp[cur_core][31:0];
            3: exp_rdata = m_cmp[cur_core][63:32];
            4: exp_rdata = m_mtime[31:0];
            5: exp_rdata = m_mtime[63:32];
            default: exp_rdata = 32'd0;
        endcase
        for (int i = 0; i < `CLINT_NUM_CORES; i++) begin
            m_mtip[i] = (m_mtime >= m_cmp[i]); // Compare before the writes land
        end
        next_mtime = m_mtime + 64'd1;
        if (cur_wr) begin
            case (cur_kind)
                1: m_msip[cur_core] = cur_wdata[0];
                2: m_cmp[cur_core][31:0] = cur_wdata;
                3: m_cmp[cur_core][63:32] = cur_wdata;
                4: next_mtime[31:0] = cur_wdata;
                5: next_mtime[63:32] = cur_wdata;
                default: ; // Unmapped write touches nothing
            endcase
        end
        m_mtime = next_mtime;
    endtask

    initial begin
        void'($urandom(32'h6eea8525));
        clk       = 1'b0;
        rst       = 1'b1;
        req       = '0;
        errors    = 0;
        exp_valid = 1'b0;
        exp_rdata = '0;
        exp_kind  = 0;
        m_mtime   = '0;
        for (int i = 0; i < `CLINT_NUM_CORES; i++) begin
            m_cmp[i]  = '1; // Reset parks every compare at max
            m_msip[i] = 1'b0;
            m_mtip[i] = 1'b0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            check_outputs();
            pick_request(cyc);
            step_model();
            @(negedge clk);
        end
        check_outputs();
        $display("Run complete after %0d cycles with %0d errors", RUN_CYCLES, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("Timeout: the run did not complete within %0d time units", WATCHDOG);
        $display("sim failed");
        $finish;
    end

endmodule

//--- src.f
+incdir+hdl
hdl/clint_bus_pkg.sv
hdl/clint_reg_pkg.sv
hdl/clint_reg_decode.sv
hdl/clint_timer.sv
hdl/clint_swi.sv
hdl/clint_irq_merge.sv
hdl/clint_top.sv
tests/clint_tb.sv

//--- Bender.yml
package:
  name: clint

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/clint_bus_pkg.sv
      - hdl/clint_reg_pkg.sv
      - hdl/clint_reg_decode.sv
      - hdl/clint_timer.sv
      - hdl/clint_swi.sv
      - hdl/clint_irq_merge.sv
      - hdl/clint_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/clint_tb.sv
